// File: verilog/gpio_bus_defs.svh
`ifndef GPIO_BUS_DEFS_SVH
`define GPIO_BUS_DEFS_SVH

// Number of GPIO slaves and the width of an index that picks one
`define GPIO_NUM_SLAVES 4
`define GPIO_SEL_W 2

// Address bits 17:16 select the slave, bits 15:0 are the register offset
`define GPIO_ADDR_W 18
`define GPIO_DATA_W 32

// Control/status register width, also the number of pins per slave
`define GPIO_CSR_W 9

// Register offsets inside one slave
`define GPIO_CSR_OFFSET 16'h0000
`define GPIO_CON_OFFSET 16'h0008

`endif

// File: verilog/gpio_bus_pkg.sv
`include "gpio_bus_defs.svh"

package gpio_bus_pkg;

  // Value of one control/status register and of the pins it drives
  typedef logic [`GPIO_CSR_W-1:0] csr_t;

  // Index of one GPIO slave, taken from the top address bits
  typedef logic [`GPIO_SEL_W-1:0] slave_idx_t;

  // Byte leaving a slave on the console strobe
  typedef logic [7:0] con_byte_t;

endpackage

// File: verilog/axi_lite_if.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

interface axi_lite_if;

  // Write address and data, driven by the master
  logic [`GPIO_ADDR_W-1:0] awaddr;
  logic                    awvalid;
  logic [`GPIO_DATA_W-1:0] wdata;
  logic                    wvalid;

  // Write handshake back from the slave
  logic                    wready;
  logic                    bvalid;

  // Read address, driven by the master
  logic [`GPIO_ADDR_W-1:0] araddr;
  logic                    arvalid;

  // Read data channel, the only one that waits on rready
  logic                    rvalid;
  logic [`GPIO_DATA_W-1:0] rdata;
  logic                    rlast;
  logic                    rready;

  modport master (
    output awaddr, awvalid, wdata, wvalid,
    input  wready, bvalid,
    output araddr, arvalid,
    input  rvalid, rdata, rlast,
    output rready
  );

  modport slave (
    input  awaddr, awvalid, wdata, wvalid,
    output wready, bvalid,
    input  araddr, arvalid,
    output rvalid, rdata, rlast,
    input  rready
  );

endinterface

// File: verilog/axi_gpio.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module axi_gpio (
  input                            clk,
  input                            rst,
  axi_lite_if.slave                bus,
  output gpio_bus_pkg::csr_t       csr,
  output logic                     con_valid,
  output gpio_bus_pkg::con_byte_t  con_data
);

  localparam int OFF_MSB = `GPIO_ADDR_W - `GPIO_SEL_W - 1;

  logic [OFF_MSB:0] aw_off;
  logic [OFF_MSB:0] ar_off;

  logic csr_wr_pend; // Write address seen for the CSR, waiting for data
  logic con_wr_pend; // Same for the console register
  logic rd_pend;
  logic bvalid_q;
  logic con_valid_q;
  logic accept;

  gpio_bus_pkg::csr_t      csr_q;
  gpio_bus_pkg::csr_t      rd_data_q;
  gpio_bus_pkg::con_byte_t con_data_q;

  assign aw_off = bus.awaddr[OFF_MSB:0];
  assign ar_off = bus.araddr[OFF_MSB:0];

  // Data is taken in the same cycle it shows up once an address is pending
  assign accept     = bus.wvalid && (csr_wr_pend || con_wr_pend);
  assign bus.wready = accept;
  assign bus.bvalid = bvalid_q;

  assign bus.rvalid = rd_pend;
  assign bus.rlast  = rd_pend; // Every read is a single beat
  assign bus.rdata  = rd_pend ? `GPIO_DATA_W'(rd_data_q) : '0;

  assign csr       = csr_q;
  assign con_valid = con_valid_q;
  assign con_data  = con_data_q;

  always_ff @(posedge clk) begin
    if (!rst) begin
      csr_wr_pend <= 1'b0;
      con_wr_pend <= 1'b0;
      bvalid_q    <= 1'b0;
      con_valid_q <= 1'b0;
      csr_q       <= '0;
    end else begin
      bvalid_q    <= accept;
      con_valid_q <= 1'b0;

      if (bus.wvalid && csr_wr_pend) begin
        csr_q       <= bus.wdata[`GPIO_CSR_W-1:0];
        csr_wr_pend <= 1'b0;
      end
      if (bus.wvalid && con_wr_pend) begin
        con_valid_q <= 1'b1;
        con_wr_pend <= 1'b0;
      end

      // A new address arms the matching flag; other offsets are ignored
      if (bus.awvalid && aw_off == `GPIO_CSR_OFFSET) begin
        csr_wr_pend <= 1'b1;
      end
      if (bus.awvalid && aw_off == `GPIO_CON_OFFSET) begin
        con_wr_pend <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      rd_pend <= 1'b0;
    end else if (bus.arvalid && ar_off == `GPIO_CSR_OFFSET) begin
      rd_pend <= 1'b1;
    end else if (rd_pend && bus.rready) begin
      rd_pend <= 1'b0;
    end
  end

  // Read data is captured with the address so it holds through rready stalls
  always_ff @(posedge clk) begin
    if (bus.arvalid && ar_off == `GPIO_CSR_OFFSET) begin
      rd_data_q <= csr_q;
    end
    if (bus.wvalid && con_wr_pend) begin
      con_data_q <= bus.wdata[7:0];
    end
  end

endmodule

// File: verilog/axi_addr_decoder.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module axi_addr_decoder (
  input                              clk,
  input                              rst,
  axi_lite_if.slave                  up,
  axi_lite_if.master                 down [`GPIO_NUM_SLAVES],
  output gpio_bus_pkg::slave_idx_t   wr_sel,
  output gpio_bus_pkg::slave_idx_t   rd_sel
);

  localparam int OFF_MSB = `GPIO_ADDR_W - `GPIO_SEL_W - 1;

  gpio_bus_pkg::slave_idx_t aw_idx;
  gpio_bus_pkg::slave_idx_t ar_idx;

  // Top address bits pick the slave
  assign aw_idx = up.awaddr[`GPIO_ADDR_W-1 -: `GPIO_SEL_W];
  assign ar_idx = up.araddr[`GPIO_ADDR_W-1 -: `GPIO_SEL_W];

  for (genvar i = 0; i < `GPIO_NUM_SLAVES; i++) begin : g_down
    // Slaves only see their own offset, the select bits are cleared
    assign down[i].awaddr  = {{`GPIO_SEL_W{1'b0}}, up.awaddr[OFF_MSB:0]};
    assign down[i].araddr  = {{`GPIO_SEL_W{1'b0}}, up.araddr[OFF_MSB:0]};
    assign down[i].wdata   = up.wdata;

    assign down[i].awvalid = up.awvalid && (aw_idx == gpio_bus_pkg::slave_idx_t'(i));
    assign down[i].arvalid = up.arvalid && (ar_idx == gpio_bus_pkg::slave_idx_t'(i));

    // Data and read back-pressure follow the transfer that is in flight
    assign down[i].wvalid  = up.wvalid && (wr_sel == gpio_bus_pkg::slave_idx_t'(i));
    assign down[i].rready  = up.rready && (rd_sel == gpio_bus_pkg::slave_idx_t'(i));
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      wr_sel <= '0;
      rd_sel <= '0;
    end else begin
      if (up.awvalid) begin
        wr_sel <= aw_idx;
      end
      if (up.arvalid) begin
        rd_sel <= ar_idx;
      end
    end
  end

endmodule

// File: verilog/axi_resp_mux.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module axi_resp_mux (
  axi_lite_if.master                down [`GPIO_NUM_SLAVES],
  input  gpio_bus_pkg::slave_idx_t  wr_sel,
  input  gpio_bus_pkg::slave_idx_t  rd_sel,
  axi_lite_if.slave                 up,
  input  logic                      con_valid_in [`GPIO_NUM_SLAVES],
  input  gpio_bus_pkg::con_byte_t   con_data_in [`GPIO_NUM_SLAVES],
  output logic                      con_valid,
  output gpio_bus_pkg::con_byte_t   con_data
);

  logic               wready_w [`GPIO_NUM_SLAVES];
  logic               bvalid_w [`GPIO_NUM_SLAVES];
  logic               rvalid_w [`GPIO_NUM_SLAVES];
  logic               rlast_w  [`GPIO_NUM_SLAVES];
  gpio_bus_pkg::csr_t rdata_w  [`GPIO_NUM_SLAVES];

  // Interface arrays need constant indices, so the replies are flattened first
  for (genvar i = 0; i < `GPIO_NUM_SLAVES; i++) begin : g_gather
    assign wready_w[i] = down[i].wready;
    assign bvalid_w[i] = down[i].bvalid;
    assign rvalid_w[i] = down[i].rvalid;
    assign rlast_w[i]  = down[i].rlast;
    assign rdata_w[i]  = down[i].rdata[`GPIO_CSR_W-1:0]; // Only the CSR is readable
  end

  // Write channel
  assign up.wready = wready_w[wr_sel];
  assign up.bvalid = bvalid_w[wr_sel];

  // Read channel
  assign up.rvalid = rvalid_w[rd_sel];
  assign up.rlast  = rlast_w[rd_sel];
  assign up.rdata  = `GPIO_DATA_W'(rdata_w[rd_sel]);

  // Console writes travel on the write channel, so they follow wr_sel too
  assign con_valid = con_valid_in[wr_sel];
  assign con_data  = con_data_in[wr_sel];

endmodule

// File: verilog/gpio_subsystem.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module gpio_subsystem (
  input                                           clk,
  input                                           rst,
  input  [`GPIO_ADDR_W-1:0]                       awaddr,
  input                                           awvalid,
  input  [`GPIO_DATA_W-1:0]                       wdata,
  input                                           wvalid,
  output                                          wready,
  output                                          bvalid,
  input  [`GPIO_ADDR_W-1:0]                       araddr,
  input                                           arvalid,
  output                                          rvalid,
  output [`GPIO_DATA_W-1:0]                       rdata,
  output                                          rlast,
  input                                           rready,
  output [`GPIO_NUM_SLAVES*`GPIO_CSR_W-1:0]       csr,
  output                                          con_valid,
  output [7:0]                                    con_data
);

  axi_lite_if up_link ();
  axi_lite_if down_link [`GPIO_NUM_SLAVES] ();

  gpio_bus_pkg::slave_idx_t wr_sel;
  gpio_bus_pkg::slave_idx_t rd_sel;
  logic                     con_valid_w [`GPIO_NUM_SLAVES];
  gpio_bus_pkg::con_byte_t  con_data_w  [`GPIO_NUM_SLAVES];

  // Master side of the upstream link comes straight from the ports
  assign up_link.awaddr  = awaddr;
  assign up_link.awvalid = awvalid;
  assign up_link.wdata   = wdata;
  assign up_link.wvalid  = wvalid;
  assign up_link.araddr  = araddr;
  assign up_link.arvalid = arvalid;
  assign up_link.rready  = rready;

  assign wready = up_link.wready;
  assign bvalid = up_link.bvalid;
  assign rvalid = up_link.rvalid;
  assign rdata  = up_link.rdata;
  assign rlast  = up_link.rlast;

  axi_addr_decoder u_decoder (
    .clk    (clk),
    .rst    (rst),
    .up     (up_link),
    .down   (down_link),
    .wr_sel (wr_sel),
    .rd_sel (rd_sel)
  );

  for (genvar i = 0; i < `GPIO_NUM_SLAVES; i++) begin : g_slave
    axi_gpio u_gpio (
      .clk       (clk),
      .rst       (rst),
      .bus       (down_link[i]),
      .csr       (csr[i*`GPIO_CSR_W +: `GPIO_CSR_W]), // Slave 0 in the low bits
      .con_valid (con_valid_w[i]),
      .con_data  (con_data_w[i])
    );
  end

  axi_resp_mux u_resp_mux (
    .down         (down_link),
    .wr_sel       (wr_sel),
    .rd_sel       (rd_sel),
    .up           (up_link),
    .con_valid_in (con_valid_w),
    .con_data_in  (con_data_w),
    .con_valid    (con_valid),
    .con_data     (con_data)
  );

endmodule

// File: testbench/gpio_bus_checker.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module gpio_bus_checker (
  input                    clk,
  input                    rst,
  input                    wvalid,
  input                    wready,
  input                    bvalid,
  input                    rvalid,
  input                    rready,
  input [`GPIO_DATA_W-1:0] rdata,
  input                    rlast
);

  // Each accepted data beat gets exactly one response cycle
  a_bvalid_pulse: assert property (@(posedge clk) disable iff (!rst)
    (wvalid && wready) |=> bvalid ##1 !bvalid)
    else $error("bvalid did not pulse for exactly one cycle after an accepted write");

  // Read data holds while the master stalls
  a_read_hold: assert property (@(posedge clk) disable iff (!rst)
    (rvalid && !rready) |=> (rvalid && $stable(rdata)))
    else $error("rvalid or rdata changed while rready was low");

  a_rlast: assert property (@(posedge clk) disable iff (!rst)
    rlast == rvalid) // Single beat reads only
    else $error("rlast differs from rvalid");

  a_wready: assert property (@(posedge clk) disable iff (!rst)
    wready |-> wvalid)
    else $error("wready was high without wvalid");

endmodule

bind gpio_subsystem gpio_bus_checker u_bus_checker (
  .clk    (clk),
  .rst    (rst),
  .wvalid (wvalid),
  .wready (wready),
  .bvalid (bvalid),
  .rvalid (rvalid),
  .rready (rready),
  .rdata  (rdata),
  .rlast  (rlast)
);

// File: testbench/tb_gpio_subsystem.sv
`timescale 1ns/1ps
`include "gpio_bus_defs.svh"

module tb_gpio_subsystem;

  localparam int TIMEOUT  = 50;
  localparam int NUM_STIM = 17;

  localparam logic [1:0] OP_WR_CSR  = 2'd0;
  localparam logic [1:0] OP_WR_CON  = 2'd1;
  localparam logic [1:0] OP_RD_CSR  = 2'd2;
  localparam logic [1:0] OP_OVERLAP = 2'd3; // Write to idx held open while idx^1 is read

  typedef struct packed {
    logic [1:0]  op;
    logic [1:0]  idx;
    logic [31:0] data;
    logic [31:0] exp_val;
  } stim_t;

  logic                                     clk;
  logic                                     rst;
  logic [`GPIO_ADDR_W-1:0]                  awaddr;
  logic                                     awvalid;
  logic [`GPIO_DATA_W-1:0]                  wdata;
  logic                                     wvalid;
  logic                                     wready;
  logic                                     bvalid;
  logic [`GPIO_ADDR_W-1:0]                  araddr;
  logic                                     arvalid;
  logic                                     rvalid;
  logic [`GPIO_DATA_W-1:0]                  rdata;
  logic                                     rlast;
  logic                                     rready;
  logic [`GPIO_NUM_SLAVES*`GPIO_CSR_W-1:0]  csr;
  logic                                     con_valid;
  logic [7:0]                               con_data;

  stim_t                 stim  [NUM_STIM];
  logic [`GPIO_CSR_W-1:0] model [`GPIO_NUM_SLAVES];

  gpio_subsystem u_gpio_subsystem (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp_val);
    if (got !== exp_val) begin
      $display("FAIL time=%0t %s got=%h expected=%h", $time, name, got, exp_val);
      $display("Simulation FAILED");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("Timed out waiting for %s", what);
    $display("Simulation FAILED");
    $fatal(1, "No %s within %0d cycles", what, TIMEOUT);
  endtask

  task automatic check_pins();
    for (int i = 0; i < `GPIO_NUM_SLAVES; i++) begin
      check_value($sformatf("csr[%0d]", i), 32'(csr[i*`GPIO_CSR_W +: `GPIO_CSR_W]),
                  32'(model[i]));
    end
  endtask

  task automatic issue_write_addr(input logic [1:0] idx, input logic [15:0] off);
    @(negedge clk);
    awaddr  = {idx, off};
    awvalid = 1'b1;
    @(negedge clk);
    awvalid = 1'b0;
  endtask

  // Holds wvalid until wready, then waits for the response pulse
  task automatic send_write_data(input logic [31:0] data);
    int cnt;
    wdata  = data;
    wvalid = 1'b1;
    cnt    = 0;
    #1;
    while (!wready) begin
      if (cnt == TIMEOUT) fail_timeout("wready");
      cnt++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    wvalid = 1'b0;
    cnt    = 0;
    while (!bvalid) begin
      if (cnt == TIMEOUT) fail_timeout("bvalid");
      cnt++;
      @(negedge clk);
    end
  endtask

  task automatic finish_write(input logic [1:0] idx, input logic is_con,
                              input logic [31:0] data, input logic [31:0] exp_val);
    if (is_con) begin
      check_value("con_valid", 32'(con_valid), 32'd1);
      check_value("con_data", 32'(con_data), exp_val);
    end else begin
      model[idx] = data[`GPIO_CSR_W-1:0];
      check_value("con_valid", 32'(con_valid), 32'd0);
      check_value("csr slice", 32'(csr[idx*`GPIO_CSR_W +: `GPIO_CSR_W]), exp_val);
    end
    check_pins();
    @(negedge clk);
    check_value("bvalid", 32'(bvalid), 32'd0);
    check_value("con_valid", 32'(con_valid), 32'd0);
  endtask

  task automatic issue_read(input logic [1:0] idx);
    @(negedge clk);
    araddr  = {idx, `GPIO_CSR_OFFSET};
    arvalid = 1'b1;
    rready  = 1'b0;
    @(negedge clk);
    arvalid = 1'b0;
  endtask

  task automatic collect_read(input logic [31:0] exp_val);
    int cnt;
    int stall;
    cnt = 0;
    while (!rvalid) begin
      if (cnt == TIMEOUT) fail_timeout("rvalid");
      cnt++;
      @(negedge clk);
    end
    stall = 1 + int'($urandom % 6);
    for (int i = 0; i < stall; i++) begin
      check_value("rvalid", 32'(rvalid), 32'd1);
      check_value("rlast", 32'(rlast), 32'd1);
      check_value("rdata", rdata, exp_val);
      @(negedge clk);
    end
    check_value("rdata", rdata, exp_val);
    rready = 1'b1;
    @(negedge clk);
    rready = 1'b0;
    check_value("rvalid", 32'(rvalid), 32'd0); // Only one beat may complete
  endtask

  task automatic load_table();
    stim[0]  = '{OP_RD_CSR,  2'd0, 32'h0000_0000, 32'h0000_0000};
    stim[1]  = '{OP_RD_CSR,  2'd1, 32'h0000_0000, 32'h0000_0000};
    stim[2]  = '{OP_RD_CSR,  2'd2, 32'h0000_0000, 32'h0000_0000};
    stim[3]  = '{OP_RD_CSR,  2'd3, 32'h0000_0000, 32'h0000_0000};
    stim[4]  = '{OP_WR_CSR,  2'd1, 32'hdead_b1a5, 32'h0000_01a5};
    stim[5]  = '{OP_RD_CSR,  2'd1, 32'h0000_0000, 32'h0000_01a5};
    stim[6]  = '{OP_WR_CSR,  2'd3, 32'h0000_00ff, 32'h0000_00ff};
    stim[7]  = '{OP_WR_CON,  2'd2, 32'h1234_5641, 32'h0000_0041};
    stim[8]  = '{OP_WR_CON,  2'd1, 32'h0000_007a, 32'h0000_007a};
    stim[9]  = '{OP_RD_CSR,  2'd3, 32'h0000_0000, 32'h0000_00ff};
    stim[10] = '{OP_RD_CSR,  2'd2, 32'h0000_0000, 32'h0000_0000};
    stim[11] = '{OP_OVERLAP, 2'd0, 32'h0000_0133, 32'h0000_01a5};
    stim[12] = '{OP_RD_CSR,  2'd0, 32'h0000_0000, 32'h0000_0133};
    stim[13] = '{OP_WR_CSR,  2'd1, 32'hffff_fe00, 32'h0000_0000};
    stim[14] = '{OP_RD_CSR,  2'd1, 32'h0000_0000, 32'h0000_0000};
    stim[15] = '{OP_OVERLAP, 2'd2, 32'h0000_01ff, 32'h0000_00ff};
    stim[16] = '{OP_RD_CSR,  2'd2, 32'h0000_0000, 32'h0000_01ff};
  endtask

  initial begin
    void'($urandom(32'h8ff4));
    rst     = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wvalid  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    for (int i = 0; i < `GPIO_NUM_SLAVES; i++) begin
      model[i] = '0;
    end
    load_table();

    repeat (5) @(negedge clk);
    rst = 1'b1;

    check_pins();
    check_value("bvalid", 32'(bvalid), 32'd0);
    check_value("rvalid", 32'(rvalid), 32'd0);
    check_value("wready", 32'(wready), 32'd0);
    check_value("con_valid", 32'(con_valid), 32'd0);

    for (int n = 0; n < NUM_STIM; n++) begin
      case (stim[n].op)
        OP_WR_CSR: begin
          issue_write_addr(stim[n].idx, `GPIO_CSR_OFFSET);
          send_write_data(stim[n].data);
          finish_write(stim[n].idx, 1'b0, stim[n].data, stim[n].exp_val);
        end
        OP_WR_CON: begin
          issue_write_addr(stim[n].idx, `GPIO_CON_OFFSET);
          send_write_data(stim[n].data);
          finish_write(stim[n].idx, 1'b1, stim[n].data, stim[n].exp_val);
        end
        OP_RD_CSR: begin
          issue_read(stim[n].idx);
          collect_read(stim[n].exp_val);
        end
        default: begin
          issue_write_addr(stim[n].idx, `GPIO_CSR_OFFSET);
          issue_read(stim[n].idx ^ 2'd1);
          collect_read(stim[n].exp_val);
          send_write_data(stim[n].data);
          finish_write(stim[n].idx, 1'b0, stim[n].data, 32'(stim[n].data[`GPIO_CSR_W-1:0]));
        end
      endcase
    end

    repeat (2) @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: compile.f
+incdir+verilog
verilog/gpio_bus_pkg.sv
verilog/axi_lite_if.sv
verilog/axi_gpio.sv
verilog/axi_addr_decoder.sv
verilog/axi_resp_mux.sv
verilog/gpio_subsystem.sv
testbench/gpio_bus_checker.sv
testbench/tb_gpio_subsystem.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the GPIO subsystem testbench with Verilator and runs it.
# The exit status is nonzero when the build fails or the run ends in $fatal.

cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 \
  -f compile.f \
  --top-module tb_gpio_subsystem &&
./obj_dir/Vtb_gpio_subsystem ||
{ echo "GPIO subsystem simulation did not complete successfully"; exit 1; }
